/* design/core_access_pkg.sv */
`default_nettype none

package core_access_pkg;

  // byte address as issued by the core
  typedef logic [31:0] addr_t;

  // one bus word
  typedef logic [31:0] data_t;

  // one bit per byte lane
  typedef logic [3:0] strb_t;

  // load/store width
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_e;

  // queued request, write data already lane aligned
  typedef struct packed {
    logic         write;
    access_size_e size;
    // sign extend on load
    logic         sign;
    addr_t        addr;
    data_t        data;
    strb_t        strb;
  } mem_req_t;

endpackage

`default_nettype wire

/* design/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

  // rresp / bresp encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // single outstanding transaction master
  typedef enum logic [2:0] {
    IDLE,
    READ_ADDR,
    READ_DATA,
    WRITE_REQ,
    WRITE_RESP
  } master_state_e;

endpackage

`default_nettype wire

/* design/mem_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if;
  import core_access_pkg::*;

  // push side: one-cycle strobe
  // pop side: head present, held as a level
  logic     valid;
  mem_req_t req;
  // sink removes the head
  logic     take;

  // aligner -> fifo, no back-pressure
  modport push_src (
    output valid,
    output req
  );
  modport push_dst (
    input valid,
    input req
  );

  // fifo -> master
  modport pop_src (
    output valid,
    output req,
    input  take
  );
  modport pop_dst (
    input  valid,
    input  req,
    output take
  );

endinterface

`default_nettype wire

/* design/store_aligner.sv */
`timescale 1ns/100ps
`default_nettype none

module store_aligner (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          req_valid_i,
  input  logic                          req_write_i,
  input  core_access_pkg::access_size_e req_size_i,
  input  logic                          req_signed_i,
  input  core_access_pkg::addr_t        req_addr_i,
  input  core_access_pkg::data_t        req_wdata_i,
  mem_req_if.push_src                   push
);
  import core_access_pkg::*;

  logic [1:0]  offset;
  data_t       lane_pattern;
  logic [63:0] rotated;
  strb_t       size_mask;
  strb_t       strb;
  mem_req_t    req_d;
  mem_req_t    req_q;
  logic        valid_q;

  // byte position inside the word
  assign offset = req_addr_i[1:0];

  // low byte/half copied across the word, mask of lanes by size
  always_comb begin
    case (req_size_i)
      SIZE_BYTE: begin
        lane_pattern = {4{req_wdata_i[7:0]}};
        size_mask    = 4'b0001;
      end
      SIZE_HALF: begin
        lane_pattern = {2{req_wdata_i[15:0]}};
        size_mask    = 4'b0011;
      end
      default: begin
        lane_pattern = req_wdata_i;
        size_mask    = 4'b1111;
      end
    endcase
  end

  // rotate left by offset so the low part lands on the addressed lane
  assign rotated = {lane_pattern, lane_pattern} << {offset, 3'b000};

  // lanes past byte 3 fall off, no strobes on a load
  assign strb = req_write_i ? (size_mask << offset) : '0;

  always_comb begin
    req_d       = '0;
    req_d.write = req_write_i;
    req_d.size  = req_size_i;
    req_d.sign  = req_signed_i;
    // full address kept, master needs the offset for loads
    req_d.addr  = req_addr_i;
    req_d.data  = rotated[63:32];
    req_d.strb  = strb;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q <= req_d;
    end
  end

  assign push.valid = valid_q;
  assign push.req   = req_q;

endmodule

`default_nettype wire

/* design/mem_req_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_req_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  mem_req_if.push_dst push,
  mem_req_if.pop_src  pop,
  output logic        busy_o
);
  import core_access_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;
  // one extra bit to tell full from empty
  typedef logic [PTR_W:0]   count_t;

  localparam count_t FULL_COUNT = count_t'(FIFO_DEPTH);
  // leaves room for the request still sitting in the aligner
  localparam count_t BUSY_COUNT = count_t'(FIFO_DEPTH - 1);

  mem_req_t mem_q [FIFO_DEPTH];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  count_t   count_q;
  count_t   count_d;
  logic     do_push;
  logic     do_pop;
  logic     busy_q;

  // a push into a full buffer is dropped
  assign do_push = push.valid && (count_q != FULL_COUNT);
  assign do_pop  = pop.take && (count_q != '0);

  always_comb begin
    case ({do_push, do_pop})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      busy_q   <= 1'b0;
    end else begin
      // pointers wrap on their own, depth is a power of two
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      // threshold on next count, so busy tracks the stored count
      busy_q  <= (count_d >= BUSY_COUNT);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push.req;
    end
  end

  // head visible the cycle after its push
  assign pop.valid = (count_q != '0);
  assign pop.req   = mem_q[rd_ptr_q];
  assign busy_o    = busy_q;

endmodule

`default_nettype wire

/* design/axi_lite_master.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_lite_master (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  mem_req_if.pop_dst                pop,
  // read address
  output core_access_pkg::addr_t    axi_araddr_o,
  output logic                      axi_arvalid_o,
  input  logic                      axi_arready_i,
  // read data
  input  core_access_pkg::data_t    axi_rdata_i,
  input  axi_lite_pkg::axi_resp_e   axi_rresp_i,
  input  logic                      axi_rvalid_i,
  output logic                      axi_rready_o,
  // write address
  output core_access_pkg::addr_t    axi_awaddr_o,
  output logic                      axi_awvalid_o,
  input  logic                      axi_awready_i,
  // write data
  output core_access_pkg::data_t    axi_wdata_o,
  output core_access_pkg::strb_t    axi_wstrb_o,
  output logic                      axi_wvalid_o,
  input  logic                      axi_wready_i,
  // write response
  input  axi_lite_pkg::axi_resp_e   axi_bresp_i,
  input  logic                      axi_bvalid_i,
  output logic                      axi_bready_o,
  // core response
  output logic                      rsp_valid_o,
  output core_access_pkg::data_t    rsp_rdata_o,
  output logic                      rsp_err_o
);
  import core_access_pkg::*;
  import axi_lite_pkg::*;

  master_state_e state_q;
  master_state_e state_d;
  mem_req_t      req_q;
  logic          aw_done_q;
  logic          w_done_q;
  logic          aw_fire;
  logic          w_fire;
  logic          r_fire;
  logic          b_fire;
  logic          rsp_valid_q;
  data_t         rsp_rdata_q;
  logic          rsp_err_q;

  // move the addressed lanes down, then extend by size
  function automatic data_t format_load(data_t word, mem_req_t req);
    data_t shifted;
    shifted = word >> {req.addr[1:0], 3'b000};
    case (req.size)
      SIZE_BYTE: format_load = {{24{req.sign & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: format_load = {{16{req.sign & shifted[15]}}, shifted[15:0]};
      default:   format_load = shifted;
    endcase
  endfunction

  function automatic logic resp_is_err(axi_resp_e resp);
    return (resp == SLVERR) || (resp == DECERR);
  endfunction

  // head taken only when idle
  assign pop.take = (state_q == IDLE) && pop.valid;

  assign aw_fire = axi_awvalid_o && axi_awready_i;
  assign w_fire  = axi_wvalid_o && axi_wready_i;
  assign r_fire  = axi_rvalid_i && axi_rready_o;
  assign b_fire  = axi_bvalid_i && axi_bready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (pop.valid) begin
          state_d = pop.req.write ? WRITE_REQ : READ_ADDR;
        end
      end
      READ_ADDR: begin
        if (axi_arready_i) begin
          state_d = READ_DATA;
        end
      end
      READ_DATA: begin
        if (r_fire) begin
          state_d = IDLE;
        end
      end
      WRITE_REQ: begin
        // aw and w may be accepted in either order
        if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
          state_d = WRITE_RESP;
        end
      end
      WRITE_RESP: begin
        if (b_fire) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // fresh acceptance flags for every request
      if (pop.take) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        if (aw_fire) begin
          aw_done_q <= 1'b1;
        end
        if (w_fire) begin
          w_done_q <= 1'b1;
        end
      end
      // pulse the cycle after the ending transfer
      rsp_valid_q <= r_fire || b_fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop.take) begin
      req_q <= pop.req;
    end
    if (r_fire) begin
      rsp_rdata_q <= format_load(axi_rdata_i, req_q);
      rsp_err_q   <= resp_is_err(axi_rresp_i);
    end else if (b_fire) begin
      rsp_rdata_q <= '0;
      rsp_err_q   <= resp_is_err(axi_bresp_i);
    end
  end

  // payload held from req_q, stable while valid is up
  assign axi_araddr_o  = req_q.addr;
  assign axi_arvalid_o = (state_q == READ_ADDR);
  assign axi_rready_o  = (state_q == READ_DATA);
  assign axi_awaddr_o  = req_q.addr;
  assign axi_awvalid_o = (state_q == WRITE_REQ) && !aw_done_q;
  assign axi_wdata_o   = req_q.data;
  assign axi_wstrb_o   = req_q.strb;
  assign axi_wvalid_o  = (state_q == WRITE_REQ) && !w_done_q;
  assign axi_bready_o  = (state_q == WRITE_RESP);

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

endmodule

`default_nettype wire

/* design/data_mem_wrapper.sv */
`timescale 1ns/100ps
`default_nettype none

module data_mem_wrapper #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // core request, one-cycle strobe
  input  logic                          req_valid_i,
  input  logic                          req_write_i,
  input  core_access_pkg::access_size_e req_size_i,
  input  logic                          req_signed_i,
  input  core_access_pkg::addr_t        req_addr_i,
  input  core_access_pkg::data_t        req_wdata_i,
  // core must hold off while high
  output logic                          busy_o,
  // core response
  output logic                          rsp_valid_o,
  output core_access_pkg::data_t        rsp_rdata_o,
  output logic                          rsp_err_o,
  // axi-lite master
  output core_access_pkg::addr_t        axi_araddr_o,
  output logic                          axi_arvalid_o,
  input  logic                          axi_arready_i,
  input  core_access_pkg::data_t        axi_rdata_i,
  input  axi_lite_pkg::axi_resp_e       axi_rresp_i,
  input  logic                          axi_rvalid_i,
  output logic                          axi_rready_o,
  output core_access_pkg::addr_t        axi_awaddr_o,
  output logic                          axi_awvalid_o,
  input  logic                          axi_awready_i,
  output core_access_pkg::data_t        axi_wdata_o,
  output core_access_pkg::strb_t        axi_wstrb_o,
  output logic                          axi_wvalid_o,
  input  logic                          axi_wready_i,
  input  axi_lite_pkg::axi_resp_e       axi_bresp_i,
  input  logic                          axi_bvalid_i,
  output logic                          axi_bready_o
);

  // aligner -> fifo
  mem_req_if push_if ();
  // fifo -> master
  mem_req_if pop_if ();

  store_aligner u_store_aligner (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_size_i   (req_size_i),
    .req_signed_i (req_signed_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .push         (push_if.push_src)
  );

  mem_req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_mem_req_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push     (push_if.push_dst),
    .pop      (pop_if.pop_src),
    .busy_o   (busy_o)
  );

  axi_lite_master u_axi_lite_master (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .pop           (pop_if.pop_dst),
    .axi_araddr_o  (axi_araddr_o),
    .axi_arvalid_o (axi_arvalid_o),
    .axi_arready_i (axi_arready_i),
    .axi_rdata_i   (axi_rdata_i),
    .axi_rresp_i   (axi_rresp_i),
    .axi_rvalid_i  (axi_rvalid_i),
    .axi_rready_o  (axi_rready_o),
    .axi_awaddr_o  (axi_awaddr_o),
    .axi_awvalid_o (axi_awvalid_o),
    .axi_awready_i (axi_awready_i),
    .axi_wdata_o   (axi_wdata_o),
    .axi_wstrb_o   (axi_wstrb_o),
    .axi_wvalid_o  (axi_wvalid_o),
    .axi_wready_i  (axi_wready_i),
    .axi_bresp_i   (axi_bresp_i),
    .axi_bvalid_i  (axi_bvalid_i),
    .axi_bready_o  (axi_bready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_rdata_o   (rsp_rdata_o),
    .rsp_err_o     (rsp_err_o)
  );

endmodule

`default_nettype wire

/* tb/axi_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model (
  input  logic                    clk_i,
  // read address
  input  core_access_pkg::addr_t  araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  // read data
  output core_access_pkg::data_t  rdata_o,
  output axi_lite_pkg::axi_resp_e rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  // write address
  input  core_access_pkg::addr_t  awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  // write data
  input  core_access_pkg::data_t  wdata_i,
  input  core_access_pkg::strb_t  wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  // write response
  output axi_lite_pkg::axi_resp_e bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i
);
  import core_access_pkg::*;
  import axi_lite_pkg::*;

  // everything from here up answers slverr
  localparam addr_t ERR_BASE = 32'h0000_0400;

  data_t  mem [256];
  integer seed;
  addr_t  addr;
  data_t  wdata;
  strb_t  wstrb;
  int     aw_wait;
  int     w_wait;
  logic   aw_got;
  logic   w_got;

  // power-up contents, every index bit shows up in the word
  function automatic data_t fill_word(int unsigned idx);
    logic [7:0] b;
    b = idx[7:0];
    return {b ^ 8'h3c, b, ~b, b + 8'h81};
  endfunction

  // 0 to 3 cycles
  function automatic int rand_delay();
    return {$random(seed)} % 4;
  endfunction

  task automatic wait_cycles(int n);
    repeat (n) @(negedge clk_i);
  endtask

  // ready raised only while valid is up, so the next rising edge transfers
  task automatic serve_read();
    wait_cycles(rand_delay());
    arready_o = 1'b1;
    addr      = araddr_i;
    @(negedge clk_i);
    arready_o = 1'b0;
    wait_cycles(rand_delay());
    if (addr >= ERR_BASE) begin
      rdata_o = '0;
      rresp_o = SLVERR;
    end else begin
      rdata_o = mem[addr[9:2]];
      rresp_o = OKAY;
    end
    rvalid_o = 1'b1;
    // hold data until the master takes it
    while (!rready_i) @(negedge clk_i);
    @(negedge clk_i);
    rvalid_o = 1'b0;
  endtask

  // aw and w accepted on their own delays
  task automatic serve_write();
    aw_wait = rand_delay();
    w_wait  = rand_delay();
    aw_got  = 1'b0;
    w_got   = 1'b0;
    while (!aw_got || !w_got) begin
      awready_o = !aw_got && (aw_wait == 0);
      wready_o  = !w_got && (w_wait == 0);
      if (awready_o) begin
        addr   = awaddr_i;
        aw_got = 1'b1;
      end
      if (wready_o) begin
        wdata = wdata_i;
        wstrb = wstrb_i;
        w_got = 1'b1;
      end
      if (aw_wait > 0) aw_wait--;
      if (w_wait > 0) w_wait--;
      @(negedge clk_i);
    end
    awready_o = 1'b0;
    wready_o  = 1'b0;
    if (addr >= ERR_BASE) begin
      // error region, memory untouched
      bresp_o = SLVERR;
    end else begin
      bresp_o = OKAY;
      for (int k = 0; k < 4; k++) begin
        if (wstrb[k]) mem[addr[9:2]][8*k +: 8] = wdata[8*k +: 8];
      end
    end
    wait_cycles(rand_delay());
    bvalid_o = 1'b1;
    while (!bready_i) @(negedge clk_i);
    @(negedge clk_i);
    bvalid_o = 1'b0;
  endtask

  initial begin
    seed      = 32'hc69f_0ce6;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = OKAY;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = OKAY;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i);
    end
    // one transaction at a time, as the master issues them
    forever begin
      @(negedge clk_i);
      if (arvalid_i) begin
        serve_read();
      end else if (awvalid_i || wvalid_i) begin
        serve_write();
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_data_mem_wrapper.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_data_mem_wrapper;
  import core_access_pkg::*;
  import axi_lite_pkg::*;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned N_RANDOM   = 500;
  // word 8, merge 14, loads 30, error region 12
  localparam int unsigned N_DIRECTED = 64;
  // 20 cycles per request
  localparam int unsigned TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 20;
  localparam addr_t       ERR_BASE = 32'h0000_0400;

  // starts low without an edge at time zero
  logic         clk = 1'b0;
  logic         arst_n;
  logic         req_valid;
  logic         req_write;
  access_size_e req_size;
  logic         req_signed;
  addr_t        req_addr;
  data_t        req_wdata;
  logic         busy;
  logic         rsp_valid;
  data_t        rsp_rdata;
  logic         rsp_err;
  addr_t        axi_araddr;
  logic         axi_arvalid;
  logic         axi_arready;
  data_t        axi_rdata;
  axi_resp_e    axi_rresp;
  logic         axi_rvalid;
  logic         axi_rready;
  addr_t        axi_awaddr;
  logic         axi_awvalid;
  logic         axi_awready;
  data_t        axi_wdata;
  strb_t        axi_wstrb;
  logic         axi_wvalid;
  logic         axi_wready;
  axi_resp_e    axi_bresp;
  logic         axi_bvalid;
  logic         axi_bready;

  // byte view of the bus memory below ERR_BASE
  logic [7:0]  ref_mem [1024];
  // expected responses in issue order
  data_t       exp_rdata_q [$];
  logic        exp_err_q [$];
  string       exp_name_q [$];
  integer      seed;
  int unsigned cycle_cnt = 0;

  always #2 clk = ~clk;

  data_mem_wrapper #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .req_valid_i   (req_valid),
    .req_write_i   (req_write),
    .req_size_i    (req_size),
    .req_signed_i  (req_signed),
    .req_addr_i    (req_addr),
    .req_wdata_i   (req_wdata),
    .busy_o        (busy),
    .rsp_valid_o   (rsp_valid),
    .rsp_rdata_o   (rsp_rdata),
    .rsp_err_o     (rsp_err),
    .axi_araddr_o  (axi_araddr),
    .axi_arvalid_o (axi_arvalid),
    .axi_arready_i (axi_arready),
    .axi_rdata_i   (axi_rdata),
    .axi_rresp_i   (axi_rresp),
    .axi_rvalid_i  (axi_rvalid),
    .axi_rready_o  (axi_rready),
    .axi_awaddr_o  (axi_awaddr),
    .axi_awvalid_o (axi_awvalid),
    .axi_awready_i (axi_awready),
    .axi_wdata_o   (axi_wdata),
    .axi_wstrb_o   (axi_wstrb),
    .axi_wvalid_o  (axi_wvalid),
    .axi_wready_i  (axi_wready),
    .axi_bresp_i   (axi_bresp),
    .axi_bvalid_i  (axi_bvalid),
    .axi_bready_o  (axi_bready)
  );

  axi_mem_model u_mem (
    .clk_i     (clk),
    .araddr_i  (axi_araddr),
    .arvalid_i (axi_arvalid),
    .arready_o (axi_arready),
    .rdata_o   (axi_rdata),
    .rresp_o   (axi_rresp),
    .rvalid_o  (axi_rvalid),
    .rready_i  (axi_rready),
    .awaddr_i  (axi_awaddr),
    .awvalid_i (axi_awvalid),
    .awready_o (axi_awready),
    .wdata_i   (axi_wdata),
    .wstrb_i   (axi_wstrb),
    .wvalid_i  (axi_wvalid),
    .wready_o  (axi_wready),
    .bresp_o   (axi_bresp),
    .bvalid_o  (axi_bvalid),
    .bready_i  (axi_bready)
  );

  // power-up contents of the bus memory
  function automatic data_t fill_word(int unsigned idx);
    logic [7:0] b;
    b = idx[7:0];
    return {b ^ 8'h3c, b, ~b, b + 8'h81};
  endfunction

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                          name, expected, actual));
    end
  endtask

  // bus valid/ready, busy and response strobe all quiet
  task automatic check_idle_outputs(string name);
    check_value(name, 32'h0, {25'h0, busy, rsp_valid, axi_arvalid, axi_awvalid,
                              axi_wvalid, axi_rready, axi_bready});
  endtask

  // update the byte model, queue the expected response, then strobe
  task automatic issue(string name, logic write, access_size_e size, logic sign,
                       addr_t addr, data_t wdata);
    int unsigned nbytes;
    data_t       rdata;
    logic        err;
    nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    err    = (addr >= ERR_BASE);
    rdata  = '0;
    if (!err) begin
      // little endian with the low byte at the lowest address
      for (int k = 0; k < nbytes; k++) begin
        if (write) ref_mem[addr + k] = wdata[8*k +: 8];
        else rdata[8*k +: 8] = ref_mem[addr + k];
      end
      // sign fill of the upper bytes on signed loads
      if (!write && sign && nbytes < 4 && rdata[8*nbytes-1]) begin
        for (int k = nbytes; k < 4; k++) rdata[8*k +: 8] = 8'hff;
      end
    end
    exp_name_q.push_back(name);
    exp_rdata_q.push_back(rdata);
    exp_err_q.push_back(err);
    // core must hold off while busy
    while (busy) @(negedge clk);
    req_valid  = 1'b1;
    req_write  = write;
    req_size   = size;
    req_signed = sign;
    req_addr   = addr;
    req_wdata  = wdata;
    @(negedge clk);
    req_valid  = 1'b0;
  endtask

  task automatic word_write_read();
    addr_t a;
    for (int i = 0; i < 4; i++) begin
      a = 32'h10 + 32'h44 * i;
      issue("word write", 1'b1, SIZE_WORD, 1'b0, a, $random(seed));
      issue("word read", 1'b0, SIZE_WORD, 1'b0, a, '0);
    end
  endtask

  // each sub-word store followed by a word read of its word
  task automatic sub_word_merge();
    for (int off = 0; off < 4; off++) begin
      issue($sformatf("byte write off %0d", off), 1'b1, SIZE_BYTE, 1'b0,
            32'h80 + off, $random(seed));
      issue("byte merge read", 1'b0, SIZE_WORD, 1'b0, 32'h80, '0);
    end
    // halves that fit inside the word
    for (int off = 0; off < 3; off++) begin
      issue($sformatf("half write off %0d", off), 1'b1, SIZE_HALF, 1'b0,
            32'ha0 + off, $random(seed));
      issue("half merge read", 1'b0, SIZE_WORD, 1'b0, 32'ha0, '0);
    end
  endtask

  // lanes with and without the sign bit set
  task automatic sub_word_loads();
    addr_t base;
    for (int w = 0; w < 2; w++) begin
      base = 32'hc0 + 4 * w;
      issue("load pattern write", 1'b1, SIZE_WORD, 1'b0, base,
            (w == 0) ? 32'h807f_ff01 : 32'h7f80_01ff);
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++) begin
          issue($sformatf("byte load off %0d sign %0d", off, s), 1'b0, SIZE_BYTE,
                s[0], base + off, '0);
        end
        for (int off = 0; off < 3; off++) begin
          issue($sformatf("half load off %0d sign %0d", off, s), 1'b0, SIZE_HALF,
                s[0], base + off, '0);
        end
      end
    end
  endtask

  task automatic error_region();
    addr_t a;
    for (int i = 0; i < 4; i++) begin
      a = (ERR_BASE << i) + 4 * i;
      issue("error write", 1'b1, SIZE_WORD, 1'b0, a, $random(seed));
      issue("error load", 1'b0, SIZE_BYTE, 1'b1, a + 1, '0);
      // same low bits below ERR_BASE stay untouched
      issue("error alias read", 1'b0, SIZE_WORD, 1'b0, a & 32'h3fc, '0);
    end
  endtask

  // small window so reads hit earlier writes and one in eight lands in the error region
  task automatic random_mix();
    int unsigned  pick;
    access_size_e size;
    addr_t        addr;
    for (int n = 0; n < N_RANDOM; n++) begin
      pick = {$random(seed)} % 3;
      size = (pick == 0) ? SIZE_BYTE : (pick == 1) ? SIZE_HALF : SIZE_WORD;
      addr = {$random(seed)} & 32'h0000_00fc;
      if (size == SIZE_BYTE) addr += {$random(seed)} % 4;
      else if (size == SIZE_HALF) addr += {$random(seed)} % 3;
      if (({$random(seed)} % 8) == 0) addr |= ERR_BASE;
      issue($sformatf("random %0d", n), 1'({$random(seed)} % 2), size,
            1'({$random(seed)} % 2), addr, $random(seed));
    end
  endtask

  // responses checked in order on the falling edge
  always @(negedge clk) begin : rsp_checker
    string name;
    data_t exp_rdata;
    logic  exp_err;
    if (rsp_valid === 1'b1) begin
      if (exp_name_q.size() == 0) begin
        abort_run("a response arrived with no request outstanding");
      end else begin
        name      = exp_name_q.pop_front();
        exp_rdata = exp_rdata_q.pop_front();
        exp_err   = exp_err_q.pop_front();
        check_value({name, " rdata"}, exp_rdata, rsp_rdata);
        check_value({name, " err"}, {31'h0, exp_err}, {31'h0, rsp_err});
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("run timed out waiting for responses after %0d cycles",
                          cycle_cnt));
    end
  end

  initial begin
    data_t word;
    seed       = 32'hc69f_0ce6;
    arst_n     = 1'b0;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_size   = SIZE_WORD;
    req_signed = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    for (int a = 0; a < 1024; a++) begin
      word       = fill_word(a >> 2);
      ref_mem[a] = word[8*(a%4) +: 8];
    end
    repeat (10) begin
      @(negedge clk);
      check_idle_outputs("reset");
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs("first cycle after reset");
    word_write_read();
    sub_word_merge();
    sub_word_loads();
    error_region();
    random_mix();
    // drain and then watch for stray responses
    while (exp_name_q.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/core_access_pkg.sv
design/axi_lite_pkg.sv
design/mem_req_if.sv
design/store_aligner.sv
design/mem_req_fifo.sv
design/axi_lite_master.sv
design/data_mem_wrapper.sv
tb/axi_mem_model.sv
tb/tb_data_mem_wrapper.sv

/* Bender.yml */
package:
  name: data_mem_wrapper

sources:
  - files:
      - design/core_access_pkg.sv
      - design/axi_lite_pkg.sv
      - design/mem_req_if.sv
      - design/store_aligner.sv
      - design/mem_req_fifo.sv
      - design/axi_lite_master.sv
      - design/data_mem_wrapper.sv
  - target: test
    files:
      - tb/axi_mem_model.sv
      - tb/tb_data_mem_wrapper.sv
